/* common/superscalar_pkg.sv */
/*
 * shared widths, vector types, RV32 opcode and funct constants,
 * ALU op, error status and dispatch FSM enums
 */
`default_nettype none

package superscalar_pkg;

	//////////////////////////////////////////////////////////////////////
	// sizes
	//////////////////////////////////////////////////////////////////////
	localparam int LANES    = 3;  // bundle width and lane count
	localparam int XLEN     = 32;
	localparam int NUM_REGS = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [31:0]     inst_t;
	typedef logic [4:0]      reg_idx_t;
	typedef logic [1:0]      count_t;  // 0 .. LANES

	localparam reg_idx_t ZERO_REG = 5'd0;  // x0, hardwired zero

	//////////////////////////////////////////////////////////////////////
	// encodings, supported subset only
	//////////////////////////////////////////////////////////////////////
	localparam logic [6:0] OP_REG = 7'b0110011;  // R-type ALU
	localparam logic [6:0] OP_IMM = 7'b0010011;  // I-type ALU

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_SUB  = 7'b0100000;  // sub only

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT
	} alu_op_t;

	typedef enum logic [0:0] {
		NO_ERROR     = 1'b0,
		ILLEGAL_INST = 1'b1
	} error_status_t;

	// four-phase handshake states
	typedef enum logic [1:0] {
		IDLE,
		BUSY,  // bundle in flight
		ACK    // retired, waiting for req low
	} dispatch_state_t;

endpackage

`default_nettype wire

/* common/lane_if.sv */
/*
 * issue_if  dispatch to lane, one instruction and its operands
 * result_if  lane to commit, one finished instruction
 */
`timescale 1ns/1ps
`default_nettype none

interface issue_if;
	import superscalar_pkg::*;

	logic  valid;    // single-cycle pulse
	inst_t inst;
	word_t rs1_val;
	word_t rs2_val;

	modport source (output valid, inst, rs1_val, rs2_val);
	modport sink   (input  valid, inst, rs1_val, rs2_val);
endinterface

interface result_if;
	import superscalar_pkg::*;

	logic     valid;    // single-cycle pulse
	logic     wr_en;    // already low for illegal or x0
	reg_idx_t wr_idx;
	word_t    wr_data;
	logic     illegal;

	modport source (output valid, wr_en, wr_idx, wr_data, illegal);
	modport sink   (input  valid, wr_en, wr_idx, wr_data, illegal);
endinterface

`default_nettype wire

/* dispatch/bundle_dispatch.sv */
/*
 * bundle dispatch: four-phase req/ack FSM, bundle capture,
 * register file read addressing and per-lane issue registers
 */
`timescale 1ns/1ps
`default_nettype none

module bundle_dispatch (
	input  logic                      clock,
	input  logic                      reset,
	input  logic                      req,
	output logic                      ack,
	input  superscalar_pkg::inst_t    bundle_inst  [superscalar_pkg::LANES],
	input  logic                      bundle_valid [superscalar_pkg::LANES],
	input  logic                      retired,      // pulse from commit
	output superscalar_pkg::reg_idx_t rd_idx  [2*superscalar_pkg::LANES],
	input  superscalar_pkg::word_t    rd_data [2*superscalar_pkg::LANES],
	issue_if.source                   issue   [superscalar_pkg::LANES]
);
	import superscalar_pkg::*;

	dispatch_state_t state;
	dispatch_state_t state_next;
	logic            accept;      // bundle taken on this edge
	logic            bundle_any;  // at least one valid lane

	//////////////////////////////////////////////////////////////////////
	// handshake FSM
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		bundle_any = 1'b0;
		for (int i = 0; i < LANES; i++) begin
			bundle_any = bundle_any | bundle_valid[i];
		end
	end

	assign accept = (state == IDLE) && req;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				// an empty bundle has nothing to retire, ack right away
				if (req) state_next = bundle_any ? BUSY : ACK;
			end
			BUSY: if (retired) state_next = ACK;  // wait for commit
			ACK:  if (!req) state_next = IDLE;    // phase 4
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	assign ack = (state == ACK);  // registered through state

	//////////////////////////////////////////////////////////////////////
	// operand read and issue registers
	//////////////////////////////////////////////////////////////////////
	for (genvar g = 0; g < LANES; g++) begin : g_issue
		// rs1 on even port, rs2 on odd
		assign rd_idx[2*g]   = bundle_inst[g][19:15];
		assign rd_idx[2*g+1] = bundle_inst[g][24:20];

		always_ff @(posedge clock) begin
			if (reset) begin
				issue[g].valid <= 1'b0;
			end else begin
				issue[g].valid <= accept & bundle_valid[g];  // one cycle only
			end
		end

		// operands sampled before any write of this bundle
		always_ff @(posedge clock) begin
			if (accept) begin
				issue[g].inst    <= bundle_inst[g];
				issue[g].rs1_val <= rd_data[2*g];
				issue[g].rs2_val <= rd_data[2*g+1];
			end
		end
	end

endmodule

`default_nettype wire

/* lane/exec_lane.sv */
/*
 * one execution lane: decode of the ALU subset, immediate
 * sign extension, ALU and the result register toward commit
 */
`timescale 1ns/1ps
`default_nettype none

module exec_lane (
	input  logic     clock,
	input  logic     reset,
	issue_if.sink    issue,
	result_if.source result
);
	import superscalar_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	reg_idx_t   rd;
	word_t      imm;       // sign-extended I immediate
	word_t      opnd_b;
	word_t      alu_out;
	alu_op_t    alu_op;
	logic       use_imm;
	logic       illegal;

	assign opcode = issue.inst[6:0];
	assign rd     = issue.inst[11:7];
	assign funct3 = issue.inst[14:12];
	assign funct7 = issue.inst[31:25];
	assign imm    = {{(XLEN-12){issue.inst[31]}}, issue.inst[31:20]};

	//////////////////////////////////////////////////////////////////////
	// decode
	//////////////////////////////////////////////////////////////////////
	always_comb begin
		alu_op  = ALU_ADD;
		use_imm = 1'b0;
		illegal = 1'b1;  // until proven otherwise
		case (opcode)
			OP_REG: begin
				case (funct3)
					F3_ADD_SUB: begin
						if (funct7 == F7_BASE) begin
							illegal = 1'b0;
						end else if (funct7 == F7_SUB) begin
							alu_op  = ALU_SUB;
							illegal = 1'b0;
						end
					end
					F3_SLT: begin
						alu_op  = ALU_SLT;
						illegal = (funct7 != F7_BASE);
					end
					F3_XOR: begin
						alu_op  = ALU_XOR;
						illegal = (funct7 != F7_BASE);
					end
					F3_OR: begin
						alu_op  = ALU_OR;
						illegal = (funct7 != F7_BASE);
					end
					F3_AND: begin
						alu_op  = ALU_AND;
						illegal = (funct7 != F7_BASE);
					end
					default: illegal = 1'b1;
				endcase
			end
			OP_IMM: begin
				use_imm = 1'b1;
				illegal = (funct3 != F3_ADD_SUB);  // only addi
			end
			default: illegal = 1'b1;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////////////////////////
	assign opnd_b = use_imm ? imm : issue.rs2_val;

	always_comb begin
		case (alu_op)
			ALU_SUB: alu_out = issue.rs1_val - opnd_b;
			ALU_AND: alu_out = issue.rs1_val & opnd_b;
			ALU_OR:  alu_out = issue.rs1_val | opnd_b;
			ALU_XOR: alu_out = issue.rs1_val ^ opnd_b;
			ALU_SLT: alu_out = {{(XLEN-1){1'b0}}, $signed(issue.rs1_val) < $signed(opnd_b)};
			default: alu_out = issue.rs1_val + opnd_b;  // add, addi
		endcase
	end

	// result register, valid follows issue by one cycle
	always_ff @(posedge clock) begin
		if (reset) begin
			result.valid <= 1'b0;
		end else begin
			result.valid <= issue.valid;
		end
	end

	always_ff @(posedge clock) begin
		if (issue.valid) begin
			result.wr_en   <= !illegal && (rd != ZERO_REG);
			result.wr_idx  <= rd;
			result.wr_data <= alu_out;
			result.illegal <= illegal;
		end
	end

endmodule

`default_nettype wire

/* commit/commit_unit.sv */
/*
 * commit: lane-ordered write-back to the register file, commit
 * ports, per-bundle completed count, sticky error, retired pulse
 */
`timescale 1ns/1ps
`default_nettype none

module commit_unit (
	input  logic                           clock,
	input  logic                           reset,
	result_if.sink                         result         [superscalar_pkg::LANES],
	output logic                           wr_en          [superscalar_pkg::LANES],
	output superscalar_pkg::reg_idx_t      wr_idx         [superscalar_pkg::LANES],
	output superscalar_pkg::word_t         wr_data        [superscalar_pkg::LANES],
	output logic                           retired,
	output logic                           commit_wr_en   [superscalar_pkg::LANES],
	output superscalar_pkg::reg_idx_t      commit_wr_idx  [superscalar_pkg::LANES],
	output superscalar_pkg::word_t         commit_wr_data [superscalar_pkg::LANES],
	output superscalar_pkg::count_t        completed_insts,
	output superscalar_pkg::error_status_t error_status
);
	import superscalar_pkg::*;

	logic   lane_valid   [LANES];
	logic   lane_illegal [LANES];
	logic   any_valid;    // bundle arriving this cycle
	logic   any_illegal;
	count_t done_count;   // valid and legal lanes

	// write ports straight from the lane result registers
	for (genvar g = 0; g < LANES; g++) begin : g_lane
		assign lane_valid[g]   = result[g].valid;
		assign lane_illegal[g] = result[g].illegal;
		assign wr_en[g]        = result[g].valid & result[g].wr_en;
		assign wr_idx[g]       = result[g].wr_idx;
		assign wr_data[g]      = result[g].wr_data;
	end

	always_comb begin
		any_valid   = 1'b0;
		any_illegal = 1'b0;
		done_count  = '0;
		for (int i = 0; i < LANES; i++) begin
			any_valid   = any_valid | lane_valid[i];
			any_illegal = any_illegal | (lane_valid[i] & lane_illegal[i]);
			done_count  = done_count + count_t'(lane_valid[i] & ~lane_illegal[i]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// commit registers
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			retired         <= 1'b0;
			completed_insts <= '0;
			error_status    <= NO_ERROR;
			for (int i = 0; i < LANES; i++) begin
				commit_wr_en[i] <= 1'b0;
			end
		end else begin
			retired <= any_valid;  // tells dispatch to ack
			for (int i = 0; i < LANES; i++) begin
				commit_wr_en[i] <= wr_en[i];  // one cycle, valid is a pulse
			end
			if (any_valid) completed_insts <= done_count;  // held until next bundle
			if (any_illegal) error_status <= ILLEGAL_INST;  // sticky until reset
		end
	end

	always_ff @(posedge clock) begin
		for (int i = 0; i < LANES; i++) begin
			commit_wr_idx[i]  <= wr_idx[i];
			commit_wr_data[i] <= wr_data[i];
		end
	end

endmodule

`default_nettype wire

/* logic/reg_file.sv */
/*
 * 32 x 32 register file, six combinational read ports,
 * one write port per lane, higher lane wins a collision
 */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                      clock,
	input  logic                      reset,
	input  superscalar_pkg::reg_idx_t rd_idx  [2*superscalar_pkg::LANES],
	output superscalar_pkg::word_t    rd_data [2*superscalar_pkg::LANES],
	input  logic                      wr_en   [superscalar_pkg::LANES],
	input  superscalar_pkg::reg_idx_t wr_idx  [superscalar_pkg::LANES],
	input  superscalar_pkg::word_t    wr_data [superscalar_pkg::LANES]
);
	import superscalar_pkg::*;

	word_t regs [NUM_REGS];

	// ascending lane order, last assignment wins
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < NUM_REGS; r++) begin
				regs[r] <= '0;
			end
		end else begin
			for (int i = 0; i < LANES; i++) begin
				if (wr_en[i] && (wr_idx[i] != ZERO_REG)) regs[wr_idx[i]] <= wr_data[i];
			end
		end
	end

	always_comb begin
		for (int j = 0; j < 2*LANES; j++) begin
			rd_data[j] = (rd_idx[j] == ZERO_REG) ? '0 : regs[rd_idx[j]];  // x0 reads zero
		end
	end

endmodule

`default_nettype wire

/* logic/superscalar_top.sv */
/*
 * three-way in-order pipeline top: dispatch, register file,
 * lanes and commit joined by issue and result interfaces
 */
`timescale 1ns/1ps
`default_nettype none

module superscalar_top (
	input  logic                           clock,
	input  logic                           reset,
	input  logic                           req,
	output logic                           ack,
	input  superscalar_pkg::inst_t         bundle_inst    [superscalar_pkg::LANES],
	input  logic                           bundle_valid   [superscalar_pkg::LANES],
	output logic                           commit_wr_en   [superscalar_pkg::LANES],
	output superscalar_pkg::reg_idx_t      commit_wr_idx  [superscalar_pkg::LANES],
	output superscalar_pkg::word_t         commit_wr_data [superscalar_pkg::LANES],
	output superscalar_pkg::count_t        completed_insts,
	output superscalar_pkg::error_status_t error_status
);
	import superscalar_pkg::*;

	reg_idx_t rd_idx     [2*LANES];
	word_t    rd_data    [2*LANES];
	logic     rf_wr_en   [LANES];
	reg_idx_t rf_wr_idx  [LANES];
	word_t    rf_wr_data [LANES];
	logic     retired;

	issue_if  issue_bus  [LANES] ();
	result_if result_bus [LANES] ();

	//////////////////////////////////////////////////////////////////////
	// E0 capture, E1 execute, E2 commit, E3 ack
	//////////////////////////////////////////////////////////////////////
	bundle_dispatch u_dispatch (
		.clock        (clock),
		.reset        (reset),
		.req          (req),
		.ack          (ack),
		.bundle_inst  (bundle_inst),
		.bundle_valid (bundle_valid),
		.retired      (retired),
		.rd_idx       (rd_idx),
		.rd_data      (rd_data),
		.issue        (issue_bus)
	);

	reg_file u_reg_file (
		.clock   (clock),
		.reset   (reset),
		.rd_idx  (rd_idx),
		.rd_data (rd_data),
		.wr_en   (rf_wr_en),
		.wr_idx  (rf_wr_idx),
		.wr_data (rf_wr_data)
	);

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		exec_lane u_lane (
			.clock  (clock),
			.reset  (reset),
			.issue  (issue_bus[g]),
			.result (result_bus[g])
		);
	end

	commit_unit u_commit (
		.clock           (clock),
		.reset           (reset),
		.result          (result_bus),
		.wr_en           (rf_wr_en),
		.wr_idx          (rf_wr_idx),
		.wr_data         (rf_wr_data),
		.retired         (retired),
		.commit_wr_en    (commit_wr_en),
		.commit_wr_idx   (commit_wr_idx),
		.commit_wr_data  (commit_wr_data),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

endmodule

`default_nettype wire

/* tb/superscalar_assert.sv */
/*
 * handshake and commit assertions, bound into superscalar_top
 */
`timescale 1ns/1ps
`default_nettype none

module superscalar_assert (
	input logic                      clock,
	input logic                      reset,
	input logic                      req,
	input logic                      ack,
	input logic                      commit_wr_en  [superscalar_pkg::LANES],
	input superscalar_pkg::reg_idx_t commit_wr_idx [superscalar_pkg::LANES]
);
	import superscalar_pkg::*;

	// ack may only rise on an edge that saw req high
	ack_rise: assert property (@(posedge clock) disable iff (reset)
		$rose(ack) |-> $past(req))
		else $error("ack rose while req was low");

	// and only fall once req has dropped
	ack_fall: assert property (@(posedge clock) disable iff (reset)
		$fell(ack) |-> !$past(req))
		else $error("ack fell while req was still high");

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		no_x0_write: assert property (@(posedge clock) disable iff (reset)
			commit_wr_en[g] |-> (commit_wr_idx[g] != ZERO_REG))
			else $error("commit wrote x0 on lane %0d", g);
	end

endmodule

bind superscalar_top superscalar_assert u_assert (
	.clock         (clock),
	.reset         (reset),
	.req           (req),
	.ack           (ack),
	.commit_wr_en  (commit_wr_en),
	.commit_wr_idx (commit_wr_idx)
);

`default_nettype wire

/* tb/tb_superscalar.sv */
/*
 * testbench for superscalar_top: clock and reset, random bundles,
 * four-phase driver, shadow register model, commit and status checks
 */
`timescale 1ns/1ps
`default_nettype none

module tb_superscalar;
	import superscalar_pkg::*;

	localparam int NUM_BUNDLES = 400;
	localparam int TIMEOUT     = 20;  // cycles per wait loop

	logic          clock;
	logic          reset;
	logic          req;
	logic          ack;
	inst_t         bundle_inst    [LANES];
	logic          bundle_valid   [LANES];
	logic          commit_wr_en   [LANES];
	reg_idx_t      commit_wr_idx  [LANES];
	word_t         commit_wr_data [LANES];
	count_t        completed_insts;
	error_status_t error_status;

	word_t         shadow   [NUM_REGS];  // reference register file
	logic          exp_en   [LANES];
	reg_idx_t      exp_idx  [LANES];
	word_t         exp_data [LANES];
	count_t        exp_count;
	error_status_t exp_error;           // sticky, like the DUT
	int            value_errors;
	int            other_errors;
	logic          hung;                // a wait ran out

	superscalar_top u_dut (
		.clock           (clock),
		.reset           (reset),
		.req             (req),
		.ack             (ack),
		.bundle_inst     (bundle_inst),
		.bundle_valid    (bundle_valid),
		.commit_wr_en    (commit_wr_en),
		.commit_wr_idx   (commit_wr_idx),
		.commit_wr_data  (commit_wr_data),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;  // 10 ns

	task automatic value_error(input string msg);
		$display("** Error at %0t: %s", $time, msg);
		value_errors++;
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////
	// returns legality, value by the RV32 rules of the subset
	function automatic logic model_exec(input inst_t inst, input word_t a, input word_t b,
			output word_t value);
		logic [6:0] op;
		logic [2:0] f3;
		logic [6:0] f7;
		op    = inst[6:0];
		f3    = inst[14:12];
		f7    = inst[31:25];
		value = '0;
		if (op == OP_IMM && f3 == F3_ADD_SUB) begin
			value = a + {{(XLEN-12){inst[31]}}, inst[31:20]};  // addi
			return 1'b1;
		end
		if (op != OP_REG) return 1'b0;
		case ({f7, f3})
			{F7_BASE, F3_ADD_SUB}: value = a + b;
			{F7_SUB,  F3_ADD_SUB}: value = a - b;
			{F7_BASE, F3_AND}:     value = a & b;
			{F7_BASE, F3_OR}:      value = a | b;
			{F7_BASE, F3_XOR}:     value = a ^ b;
			{F7_BASE, F3_SLT}:     value = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
			default:               return 1'b0;
		endcase
		return 1'b1;
	endfunction

	task automatic model_bundle();
		word_t value [LANES];
		logic  legal [LANES];
		exp_count = '0;
		for (int i = 0; i < LANES; i++) begin
			exp_en[i]   = 1'b0;
			exp_idx[i]  = bundle_inst[i][11:7];
			exp_data[i] = '0;
			if (bundle_valid[i]) begin
				// operands from the state before the bundle
				legal[i] = model_exec(bundle_inst[i], shadow[bundle_inst[i][19:15]],
					shadow[bundle_inst[i][24:20]], value[i]);
				if (legal[i]) exp_count = exp_count + 2'd1;
				else exp_error = ILLEGAL_INST;
				exp_en[i]   = legal[i] && (exp_idx[i] != ZERO_REG);
				exp_data[i] = value[i];
			end
		end
		for (int i = 0; i < LANES; i++) begin
			if (exp_en[i]) shadow[exp_idx[i]] = exp_data[i];  // later lane wins
		end
	endtask

	// ~5% illegal, rd in x0..x7 for frequent collisions
	function automatic inst_t random_inst();
		int          kind;
		reg_idx_t    rd;
		reg_idx_t    rs1;
		reg_idx_t    rs2;
		logic [11:0] imm;
		kind = int'($urandom % 100);
		rd   = reg_idx_t'($urandom % 8);
		rs1  = reg_idx_t'($urandom % 8);
		rs2  = reg_idx_t'($urandom % 8);
		imm  = 12'($urandom);  // half of them negative
		if (kind < 5) begin
			case ($urandom % 3)
				0:       return {7'b0000001, rs2, rs1, 3'($urandom), rd, OP_REG};  // M ext
				1:       return {imm, rs1, 3'b010, rd, OP_IMM};                    // slti
				default: return {imm, rs1, 3'b000, rd, 7'b0000011};                // load
			endcase
		end
		if (kind < 35) return {imm, rs1, F3_ADD_SUB, rd, OP_IMM};
		case (kind % 6)
			0:       return {F7_BASE, rs2, rs1, F3_ADD_SUB, rd, OP_REG};
			1:       return {F7_SUB,  rs2, rs1, F3_ADD_SUB, rd, OP_REG};
			2:       return {F7_BASE, rs2, rs1, F3_AND, rd, OP_REG};
			3:       return {F7_BASE, rs2, rs1, F3_OR, rd, OP_REG};
			4:       return {F7_BASE, rs2, rs1, F3_XOR, rd, OP_REG};
			default: return {F7_BASE, rs2, rs1, F3_SLT, rd, OP_REG};
		endcase
	endfunction

	//////////////////////////////////////////////////////////////////////
	// four-phase driver and checks
	//////////////////////////////////////////////////////////////////////
	task automatic check_commit();
		for (int i = 0; i < LANES; i++) begin
			if (commit_wr_en[i] !== exp_en[i]) begin
				value_error($sformatf("lane %0d commit_wr_en %b, expected %b",
					i, commit_wr_en[i], exp_en[i]));
			end else if (exp_en[i] && (commit_wr_idx[i] !== exp_idx[i] ||
					commit_wr_data[i] !== exp_data[i])) begin
				value_error($sformatf("lane %0d wrote x%0d=%h, expected x%0d=%h", i,
					commit_wr_idx[i], commit_wr_data[i], exp_idx[i], exp_data[i]));
			end
		end
	endtask

	// called on a falling edge with the bundle already set up
	task automatic run_bundle();
		int n;
		model_bundle();
		req = 1'b1;
		n   = 0;
		do begin
			@(negedge clock);
			n++;
			if (n == 3) begin
				check_commit();  // E0 + 3
			end else begin
				for (int i = 0; i < LANES; i++) begin
					if (commit_wr_en[i] !== 1'b0)
						value_error($sformatf("lane %0d commit %0d cycles after req", i, n));
				end
			end
		end while (!ack && n < TIMEOUT);
		if (!ack) begin
			$display("timeout: DUT did not raise ack within %0d cycles", TIMEOUT);
			other_errors++;
			hung = 1'b1;
			return;
		end
		if (n != 4) value_error($sformatf("ack rose after %0d cycles, expected 4", n));
		if (completed_insts !== exp_count)
			value_error($sformatf("completed_insts %0d, expected %0d", completed_insts, exp_count));
		if (error_status !== exp_error)
			value_error($sformatf("error_status %0d, expected %0d", error_status, exp_error));
		req = 1'b0;  // phase 3
		n   = 0;
		do begin
			@(negedge clock);
			n++;
		end while (ack && n < TIMEOUT);
		if (ack) begin
			$display("timeout: DUT kept ack high for %0d cycles after req fell", TIMEOUT);
			other_errors++;
			hung = 1'b1;
		end else if (n != 1) begin
			value_error($sformatf("ack fell %0d cycles after req, expected 1", n));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////////////
	initial begin
		int unsigned seed_ret;
		logic        nonempty;
		seed_ret     = $urandom(32'h06ec_e66d);
		reset        = 1'b1;
		req          = 1'b0;
		value_errors = 0;
		other_errors = 0;
		hung         = 1'b0;
		exp_error    = NO_ERROR;
		for (int i = 0; i < LANES; i++) begin
			bundle_inst[i]  = '0;
			bundle_valid[i] = 1'b0;
		end
		for (int r = 0; r < NUM_REGS; r++) shadow[r] = '0;

		repeat (5) @(negedge clock);
		reset = 1'b0;
		// state right after reset
		if (ack !== 1'b0) value_error("ack high after reset");
		for (int i = 0; i < LANES; i++) begin
			if (commit_wr_en[i] !== 1'b0) value_error($sformatf("lane %0d commit after reset", i));
		end
		if (completed_insts !== 2'd0) value_error("completed_insts not 0 after reset");
		if (error_status !== NO_ERROR) value_error("error_status set after reset");

		for (int b = 0; b < NUM_BUNDLES && !hung; b++) begin
			nonempty = 1'b0;
			for (int i = 0; i < LANES; i++) begin
				bundle_inst[i]  = random_inst();
				bundle_valid[i] = ($urandom % 4) != 0;
				nonempty        = nonempty | bundle_valid[i];
			end
			if (!nonempty) bundle_valid[int'($urandom % LANES)] = 1'b1;  // empty acks early
			run_bundle();
		end

		// readback: addi xr, xr, 0 shows every register through commit
		for (int r = 1; r < NUM_REGS && !hung; r += LANES) begin
			for (int i = 0; i < LANES; i++) begin
				bundle_inst[i] = {12'd0, reg_idx_t'((r + i) % NUM_REGS), F3_ADD_SUB,
					reg_idx_t'((r + i) % NUM_REGS), OP_IMM};
				bundle_valid[i] = (r + i) < NUM_REGS;
			end
			run_bundle();
		end

		$display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
common/superscalar_pkg.sv
common/lane_if.sv
dispatch/bundle_dispatch.sv
lane/exec_lane.sv
commit/commit_unit.sv
logic/reg_file.sv
logic/superscalar_top.sv
tb/superscalar_assert.sv
tb/tb_superscalar.sv

/* Makefile */
# Verilator build and run of the superscalar pipeline testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_superscalar
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check the log for the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
